/* scc_pkg.sv */
// shared sizes and bus structs; single slot, plain wave chip only, no enhanced mode
`default_nettype none

package scc_pkg;

    localparam int num_channels = 5;
    localparam int wave_len = 32;          // samples per waveform
    localparam int wave_banks = 4;         // channel 4 reuses bank 3
    localparam int sound_width = 15;
    localparam int prod_width = 13;        // signed byte times 4-bit volume
    localparam int chan_width = $clog2(num_channels);
    localparam int phase_width = $clog2(wave_len);

    // bank registers after reset, entry i is bank i
    localparam logic [3:0][7:0] bank_reset = {8'h03, 8'h02, 8'h01, 8'h00};

    localparam logic [7:0] scc_select_bank = 8'h3F;  // bank 2 value that maps the chip

    // one CPU access toward the sound chip
    typedef struct packed {
        logic       write;
        logic [7:0] addr;                  // offset inside 9800h window
        logic [7:0] data;
    } bus_req_t;

    // item leaving the tone stage
    typedef struct packed {
        logic [chan_width-1:0]  chan;
        logic [phase_width-1:0] phase;
        logic                   valid;
        logic                   last;      // channel 4, closes the frame
    } tone_slot_t;

    // item leaving the register stage
    typedef struct packed {
        logic signed [7:0] wave;
        logic [3:0]        volume;         // zero when channel disabled
        logic              valid;
        logic              last;
    } voice_sample_t;

    // per channel setting handed to the tone stage
    typedef struct packed {
        logic [11:0] period;
        logic        enable;
    } chan_cfg_t;

endpackage

`default_nettype wire

/* scc_cart_mapper.sv */
// four 8 KB banks, no RAM segments; rom_size must be a power of two in 8 KB pages
`timescale 1ns/100ps
`default_nettype none

module scc_cart_mapper (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    cs,
    input  wire                    rd,
    input  wire                    wr,
    input  wire  [15:0]            addr,
    input  wire  [7:0]             d_from_cpu,
    input  wire  [24:0]            rom_size,
    output logic [24:0]            mem_addr,
    output logic                   mem_oe,
    output logic                   scc_req,
    output scc_pkg::bus_req_t      bus_req
);

    logic [7:0] bank [4];
    logic [7:0] bank_base;
    logic [7:0] page_mask;
    logic       scc_window;

    // bank register writes
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 4; i++) begin
                bank[i] <= scc_pkg::bank_reset[i];
            end
        end else if (cs && wr) begin
            case (addr[15:11])
                5'b01010: bank[0] <= d_from_cpu;  // 5000-57ffh
                5'b01110: bank[1] <= d_from_cpu;  // 7000-77ffh
                5'b10010: bank[2] <= d_from_cpu;  // 9000-97ffh
                5'b10110: bank[3] <= d_from_cpu;  // b000-b7ffh
                default: ;
            endcase
        end
    end

    // page count minus one; sizes of 2 MB and up leave all bits
    assign page_mask = rom_size[20:13] - 8'd1;

    always_comb begin
        case (addr[15:13])
            3'b010:  bank_base = bank[0];  // 4000-5fffh
            3'b011:  bank_base = bank[1];  // 6000-7fffh
            3'b100:  bank_base = bank[2];  // 8000-9fffh
            3'b101:  bank_base = bank[3];  // a000-bfffh
            default: bank_base = 8'h00;
        endcase
    end

    assign mem_addr = {4'h0, bank_base & page_mask, addr[12:0]};
    assign mem_oe = cs;

    // chip sits in 9800-98ffh only while bank 2 selects it
    assign scc_window = (bank[2] == scc_pkg::scc_select_bank) && (addr[15:8] == 8'h98);
    assign scc_req = scc_window && cs && (rd || wr);

    assign bus_req.write = wr;
    assign bus_req.addr = addr[7:0];
    assign bus_req.data = d_from_cpu;

endmodule

`default_nettype wire

/* scc_wave_regs.sv */
// requester must drop scc_req after scc_ack before a new access is taken; channel 4 shares wave 3
`timescale 1ns/100ps
`default_nettype none

module scc_wave_regs (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      scc_req,
    input  wire  scc_pkg::bus_req_t  bus_req,
    output logic                     scc_ack,
    output logic [7:0]               d_to_cpu,
    output logic                     cart_oe,
    output scc_pkg::chan_cfg_t       chan_cfg [scc_pkg::num_channels],
    input  wire  scc_pkg::tone_slot_t slot_in,
    output scc_pkg::voice_sample_t   voice_out
);

    localparam int ram_depth = scc_pkg::wave_banks * scc_pkg::wave_len;

    logic [7:0]  wave_ram [ram_depth];
    logic [11:0] period [scc_pkg::num_channels];
    logic [3:0]  volume [scc_pkg::num_channels];
    logic [scc_pkg::num_channels-1:0] enable;

    logic       req_held;
    logic       req_new;
    logic       reg_write;
    logic [2:0] per_sel;
    logic [2:0] vol_sel;
    logic [7:0] cpu_rd_data;
    logic [1:0] fetch_bank;

    assign req_new = scc_req && !req_held;   // first cycle of a request
    assign reg_write = req_new && bus_req.write;

    assign per_sel = bus_req.addr[3:1];      // 80h-89h, two bytes per channel
    assign vol_sel = 3'(bus_req.addr[3:0] - 4'd10);  // 8ah-8eh

    // acknowledge and CPU read data
    always_ff @(posedge clk) begin
        if (reset) begin
            req_held <= 1'b0;
            scc_ack <= 1'b0;
            cart_oe <= 1'b0;
        end else begin
            req_held <= scc_req;
            scc_ack <= req_new;
            cart_oe <= req_new && !bus_req.write;  // drive data on reads only
        end
    end

    assign cpu_rd_data = bus_req.addr[7] ? 8'hFF : wave_ram[bus_req.addr[6:0]];

    always_ff @(posedge clk) begin
        if (req_new) begin
            d_to_cpu <= cpu_rd_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < ram_depth; i++) begin
                wave_ram[i] <= 8'h00;
            end
        end else if (reg_write && !bus_req.addr[7]) begin
            wave_ram[bus_req.addr[6:0]] <= bus_req.data;
        end
    end

    // period, volume and enable registers
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < scc_pkg::num_channels; i++) begin
                period[i] <= 12'h000;
                volume[i] <= 4'h0;
            end
            enable <= '0;
        end else if (reg_write && bus_req.addr[7:4] == 4'h8) begin
            if (bus_req.addr[3:0] <= 4'h9) begin
                if (!bus_req.addr[0]) begin
                    period[per_sel][7:0] <= bus_req.data;
                end else begin
                    period[per_sel][11:8] <= bus_req.data[3:0];  // upper nibble
                end
            end else if (bus_req.addr[3:0] != 4'hF) begin
                volume[vol_sel] <= bus_req.data[3:0];
            end else begin
                enable <= bus_req.data[scc_pkg::num_channels-1:0];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < scc_pkg::num_channels; i++) begin
            chan_cfg[i].period = period[i];
            chan_cfg[i].enable = enable[i];
        end
    end

    // fetch stage of the sound pipeline
    assign fetch_bank = (slot_in.chan == 3'(scc_pkg::num_channels - 1)) ? 2'd3 :
                        slot_in.chan[1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            voice_out <= '0;
        end else begin
            voice_out.valid <= slot_in.valid;
            voice_out.last <= slot_in.last;
            voice_out.wave <= wave_ram[{fetch_bank, slot_in.phase}];
            voice_out.volume <= enable[slot_in.chan] ? volume[slot_in.chan] : 4'h0;
        end
    end

endmodule

`default_nettype wire

/* scc_tone_gen.sv */
// one channel per clk_en, so each counter steps once per five enables; disabled channels hold
`timescale 1ns/100ps
`default_nettype none

module scc_tone_gen (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      clk_en,
    input  wire  scc_pkg::chan_cfg_t chan_cfg [scc_pkg::num_channels],
    output scc_pkg::tone_slot_t      slot_out
);

    localparam logic [scc_pkg::chan_width-1:0] last_chan =
        scc_pkg::chan_width'(scc_pkg::num_channels - 1);

    logic [scc_pkg::chan_width-1:0]  chan;
    logic [11:0]                     count [scc_pkg::num_channels];
    logic [scc_pkg::phase_width-1:0] phase [scc_pkg::num_channels];
    logic                            is_last;

    assign is_last = (chan == last_chan);

    always_ff @(posedge clk) begin
        if (reset) begin
            chan <= '0;
            slot_out <= '0;
            for (int i = 0; i < scc_pkg::num_channels; i++) begin
                count[i] <= 12'h000;
                phase[i] <= '0;
            end
        end else begin
            slot_out.valid <= clk_en;   // one item per enable
            if (clk_en) begin
                slot_out.chan <= chan;
                slot_out.phase <= phase[chan];
                slot_out.last <= is_last;
                chan <= is_last ? '0 : chan + 1'b1;

                if (!chan_cfg[chan].enable) begin
                    count[chan] <= chan_cfg[chan].period;  // keep it primed
                end else if (count[chan] == 12'h000) begin
                    count[chan] <= chan_cfg[chan].period;
                    phase[chan] <= phase[chan] + 1'b1;     // wraps at 32
                end else begin
                    count[chan] <= count[chan] - 12'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* scc_mixer.sv */
// five signed products summed per frame; the 15-bit sum cannot overflow for 8-bit waves
`timescale 1ns/100ps
`default_nettype none

module scc_mixer (
    input  wire                                  clk,
    input  wire                                  reset,
    input  wire  scc_pkg::voice_sample_t         voice_in,
    output logic signed [scc_pkg::sound_width-1:0] sound,
    output logic                                 sample_strobe
);

    logic signed [scc_pkg::prod_width-1:0]  product;
    logic signed [scc_pkg::sound_width-1:0] product_ext;
    logic signed [scc_pkg::sound_width-1:0] acc;

    // volume is unsigned, widen it before the signed multiply
    assign product = $signed(voice_in.wave) * $signed({1'b0, voice_in.volume});
    assign product_ext = {{(scc_pkg::sound_width - scc_pkg::prod_width){product[scc_pkg::prod_width-1]}},
                          product};

    always_ff @(posedge clk) begin
        if (reset) begin
            acc <= '0;
            sound <= '0;
            sample_strobe <= 1'b0;
        end else begin
            sample_strobe <= 1'b0;
            if (voice_in.valid) begin
                if (voice_in.last) begin
                    sound <= acc + product_ext;   // frame complete
                    acc <= '0;
                    sample_strobe <= 1'b1;
                end else begin
                    acc <= acc + product_ext;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* scc_cart_top.sv */
// single slot cartridge; sound is free running and updates three clocks after channel 4's clk_en
`timescale 1ns/100ps
`default_nettype none

module scc_cart_top (
    input  wire                                    clk,
    input  wire                                    reset,
    input  wire                                    clk_en,
    input  wire                                    cs,
    input  wire                                    rd,
    input  wire                                    wr,
    input  wire  [15:0]                            addr,
    input  wire  [7:0]                             d_from_cpu,
    output logic [7:0]                             d_to_cpu,
    output logic                                   cart_oe,
    input  wire  [24:0]                            rom_size,
    output logic [24:0]                            mem_addr,
    output logic                                   mem_oe,
    output logic signed [scc_pkg::sound_width-1:0] sound,
    output logic                                   sample_strobe
);

    logic                   scc_req;
    logic                   scc_ack;
    scc_pkg::bus_req_t      bus_req;
    scc_pkg::chan_cfg_t     chan_cfg [scc_pkg::num_channels];
    scc_pkg::tone_slot_t    tone_slot;
    scc_pkg::voice_sample_t voice;

    scc_cart_mapper u_mapper (
        .clk        (clk),
        .reset      (reset),
        .cs         (cs),
        .rd         (rd),
        .wr         (wr),
        .addr       (addr),
        .d_from_cpu (d_from_cpu),
        .rom_size   (rom_size),
        .mem_addr   (mem_addr),
        .mem_oe     (mem_oe),
        .scc_req    (scc_req),
        .bus_req    (bus_req)
    );

    scc_wave_regs u_wave_regs (
        .clk        (clk),
        .reset      (reset),
        .scc_req    (scc_req),
        .bus_req    (bus_req),
        .scc_ack    (scc_ack),
        .d_to_cpu   (d_to_cpu),
        .cart_oe    (cart_oe),
        .chan_cfg   (chan_cfg),
        .slot_in    (tone_slot),
        .voice_out  (voice)
    );

    scc_tone_gen u_tone_gen (
        .clk        (clk),
        .reset      (reset),
        .clk_en     (clk_en),
        .chan_cfg   (chan_cfg),
        .slot_out   (tone_slot)
    );

    scc_mixer u_mixer (
        .clk           (clk),
        .reset         (reset),
        .voice_in      (voice),
        .sound         (sound),
        .sample_strobe (sample_strobe)
    );

endmodule

`default_nettype wire

/* tb_scc_cart.sv */
// replays scc_cart_patterns.txt from the project root; chip writes are timed on the internal ack
`timescale 1ns/100ps
`default_nettype none

module tb_scc_cart;

    localparam int ack_timeout = 16;       // clocks
    localparam int strobe_timeout = 200;   // a frame is 20 clocks

    logic                                   clk;
    logic                                   reset;
    logic                                   clk_en;
    logic                                   cs;
    logic                                   rd;
    logic                                   wr;
    logic [15:0]                            addr;
    logic [7:0]                             d_from_cpu;
    logic [7:0]                             d_to_cpu;
    logic                                   cart_oe;
    logic [24:0]                            rom_size;
    logic [24:0]                            mem_addr;
    logic                                   mem_oe;
    logic signed [scc_pkg::sound_width-1:0] sound;
    logic                                   sample_strobe;

    logic [1:0]       en_phase;
    logic [8*8-1:0]   op;
    logic [8*160-1:0] skipped;
    logic [31:0]      f_addr;
    logic [31:0]      f_data;
    logic [31:0]      f_exp;
    integer           fd;
    integer           code;
    integer           line_no;

    scc_cart_top dut (
        .clk           (clk),
        .reset         (reset),
        .clk_en        (clk_en),
        .cs            (cs),
        .rd            (rd),
        .wr            (wr),
        .addr          (addr),
        .d_from_cpu    (d_from_cpu),
        .d_to_cpu      (d_to_cpu),
        .cart_oe       (cart_oe),
        .rom_size      (rom_size),
        .mem_addr      (mem_addr),
        .mem_oe        (mem_oe),
        .sound         (sound),
        .sample_strobe (sample_strobe)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        en_phase <= en_phase + 2'd1;
        clk_en <= (en_phase == 2'd3);   // every fourth clock
    end

    task automatic stop_with_failure;
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic compare_value(input logic [31:0] actual, input logic [31:0] expected,
                                 input string what);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s on pattern line %0d, got %h, expected %h",
                     $time, what, line_no, actual, expected);
            stop_with_failure();
        end
    endtask

    task automatic start_access(input logic is_write, input logic [15:0] a,
                                input logic [7:0] d);
        @(posedge clk);
        cs <= 1'b1;
        rd <= !is_write;
        wr <= is_write;
        addr <= a;
        d_from_cpu <= d;
    endtask

    task automatic release_bus;
        @(posedge clk);
        cs <= 1'b0;
        rd <= 1'b0;
        wr <= 1'b0;
    endtask

    // access in the 98xxh window, held until the chip acknowledges
    task automatic chip_access(input logic is_write, input logic [15:0] a,
                               input logic [7:0] d, input logic [7:0] expected);
        int waited;
        start_access(is_write, a, d);
        waited = 0;
        @(negedge clk);
        while (!dut.u_wave_regs.scc_ack && waited < ack_timeout) begin
            @(negedge clk);
            waited++;
        end
        if (!dut.u_wave_regs.scc_ack) begin
            $display("timed out waiting for the sound chip to acknowledge address %h", a);
            stop_with_failure();
        end else begin
            if (!is_write) begin
                compare_value(d_to_cpu, expected, "chip read data");
                compare_value(cart_oe, 1, "cart_oe on chip read");
            end
            release_bus();
        end
    endtask

    task automatic check_no_response(input logic [15:0] a);
        start_access(1'b0, a, 8'h00);
        repeat (ack_timeout) begin
            @(negedge clk);
            compare_value(cart_oe, 0, "cart_oe with sound window closed");
        end
        release_bus();
    endtask

    task automatic check_rom_address(input logic [15:0] a, input logic [31:0] expected);
        start_access(1'b0, a, 8'h00);
        @(negedge clk);
        compare_value(mem_addr, expected, "mem_addr");
        compare_value(mem_oe, 1, "mem_oe");
        release_bus();
    endtask

    // waits for a number of strobes and checks the last sample
    task automatic check_sound(input int strobes, input logic [31:0] expected);
        int waited;
        repeat (strobes) begin
            waited = 0;
            @(negedge clk);
            while (!sample_strobe && waited < strobe_timeout) begin
                @(negedge clk);
                waited++;
            end
            if (!sample_strobe) begin
                $display("timed out waiting for sample_strobe");
                stop_with_failure();
            end
        end
        compare_value({{(32 - scc_pkg::sound_width){1'b0}}, sound}, expected, "mixed sound");
    endtask

    task automatic run_op;
        int i;
        case (op)
            "size": begin
                @(posedge clk);
                rom_size <= f_data[24:0];
            end
            "bank": begin
                start_access(1'b1, f_addr[15:0], f_data[7:0]);
                release_bus();
            end
            "write": chip_access(1'b1, f_addr[15:0], f_data[7:0], 8'h00);
            "read": chip_access(1'b0, f_addr[15:0], 8'h00, f_exp[7:0]);
            "fill": begin
                for (i = 0; i < f_exp; i++) begin
                    chip_access(1'b1, f_addr[15:0] + 16'(i), f_data[7:0], 8'h00);
                end
            end
            "noack": check_no_response(f_addr[15:0]);
            "romaddr": check_rom_address(f_addr[15:0], f_exp);
            "sound": check_sound(f_data, f_exp);
            default: begin
                $display("unknown operation on pattern line %0d", line_no);
                stop_with_failure();
            end
        endcase
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        clk_en = 1'b0;
        en_phase = 2'd0;
        cs = 1'b0;
        rd = 1'b0;
        wr = 1'b0;
        addr = 16'h0000;
        d_from_cpu = 8'h00;
        rom_size = 25'h0;
        line_no = 0;
        fd = $fopen("scc_cart_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open scc_cart_patterns.txt");
            stop_with_failure();
        end else begin
            repeat (3) @(posedge clk);
            reset <= 1'b0;
            while (!$feof(fd)) begin
                code = $fscanf(fd, "%s", op);
                if (code == 1) begin
                    line_no++;
                    if (op == "#") begin
                        code = $fgets(skipped, fd);   // rest of a comment line
                    end else begin
                        code = $fscanf(fd, "%h %h %h", f_addr, f_data, f_exp);
                        if (code != 3) begin
                            $display("malformed pattern line %0d", line_no);
                            stop_with_failure();
                        end else begin
                            run_op();
                        end
                    end
                end
            end
            $fclose(fd);
            $display("No errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* scc_cart_patterns.txt */
# op addr data expected, all hex; fill data is the byte, expected the count
# sound data is the number of strobes to wait, expected the 15-bit sample
size 0000 40000 0
romaddr 4000 00 0000000
romaddr 6000 00 0002000
romaddr 8000 00 0004000
romaddr a000 00 0006000
# bank switching, 45h wraps to 05h in a 256 KB ROM
bank 5000 07 0
romaddr 4123 00 000e123
bank 7000 45 0
romaddr 7fff 00 000bfff
bank b000 1e 0
romaddr b000 00 003d000
# sound window closed until bank 2 holds 3fh
noack 9800 00 0
bank 9000 3f 0
romaddr 8000 00 003e000
write 9800 5a 0
write 981f a5 0
write 987f c3 0
read 9800 00 5a
read 981f 00 a5
read 987f 00 c3
read 98a0 00 ff
# channel 0 alone, constant 10h at volume 15
fill 9800 10 20
write 988a 0f 0
write 9880 07 0
write 9881 01 0
write 988f 01 0
sound 0000 2 0f0
sound 0000 1 0f0
write 9880 ff 0
sound 0000 2 0f0
# channels 3 and 4 share wave f0h, volumes 8 and 4
fill 9860 f0 20
write 988d 08 0
write 988e 04 0
write 988f 18 0
sound 0000 2 7f40
sound 0000 1 7f40
write 988f 00 0
sound 0000 2 0000

/* project.f */
scc_pkg.sv
scc_cart_mapper.sv
scc_wave_regs.sv
scc_tone_gen.sv
scc_mixer.sv
scc_cart_top.sv
tb_scc_cart.sv

/* Bender.yml */
package:
  name: scc_cart

sources:
  - scc_pkg.sv
  - scc_cart_mapper.sv
  - scc_wave_regs.sv
  - scc_tone_gen.sv
  - scc_mixer.sv
  - scc_cart_top.sv
  - target: test
    files:
      - tb_scc_cart.sv
